//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_pc_controller
BUILD_DIR ?= obj_dir
FILE_LIST ?= compile.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps

SOURCES := $(shell grep -v '^+' $(FILE_LIST)) $(wildcard design/*.svh)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(SIM)
	$(SIM) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q '^TEST PASSED$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- compile.f
+incdir+design
design/ctrl_pkg.sv
design/pc_mem_if.sv
design/delay_line.sv
design/thread_counter.sv
design/pc_init_fsm.sv
design/branch_condition.sv
design/thread_pc_memory.sv
design/pc_sequencer.sv
design/pc_controller.sv
tests/tb_pc_controller.sv

//--- design/branch_condition.sv
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_macros.svh"

module branch_condition (
    input  logic                     clock,
    input  logic                     rst_n,
    input  ctrl_pkg::opcode_e        op,
    input  logic [`CTRL_A_WIDTH-1:0] a_value,
    output logic                     jump
);
    ctrl_pkg::opcode_e op_q;
    logic              a_zero;
    logic              a_positive;

    // ==================================================
    // flag stage
    // ==================================================
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            op_q       <= ctrl_pkg::op_nop;
            a_zero     <= 1'b0;
            a_positive <= 1'b0;
        end else begin
            op_q       <= op;
            a_zero     <= (a_value == '0);
            a_positive <= ~a_value[`CTRL_A_WIDTH-1]; // zero counts as positive.
        end
    end

    // ==================================================
    // decision from the registered flags
    // ==================================================
    always_comb begin
        case (op_q)
            ctrl_pkg::op_jmp: jump = 1'b1;
            ctrl_pkg::op_jze: jump = a_zero;
            ctrl_pkg::op_jnz: jump = ~a_zero;
            ctrl_pkg::op_jpo: jump = a_positive;
            ctrl_pkg::op_jne: jump = ~a_positive;
            default:          jump = 1'b0;
        endcase
    end
endmodule

`default_nettype wire

//--- design/ctrl_macros.svh
`ifndef CTRL_MACROS_SVH
`define CTRL_MACROS_SVH

// ==================================================
// datapath widths
// ==================================================
// one program word address.
`define CTRL_PC_WIDTH      10
`define CTRL_A_WIDTH       16
`define CTRL_OP_WIDTH      4

// ==================================================
// barrel geometry
// ==================================================
`define CTRL_THREAD_COUNT  8
`define CTRL_THREAD_BITS   3
// thread n starts at n * stride.
`define CTRL_THREAD_STRIDE 16

`endif

//--- design/ctrl_pkg.sv
`default_nettype none

`include "ctrl_macros.svh"

package ctrl_pkg;

    // ==================================================
    // opcodes as seen by the pc controller
    // ==================================================
    typedef enum logic [`CTRL_OP_WIDTH-1:0] {
        op_nop = `CTRL_OP_WIDTH'd0,
        op_add = `CTRL_OP_WIDTH'd1,
        op_jmp = `CTRL_OP_WIDTH'd2, // unconditional.
        op_jze = `CTRL_OP_WIDTH'd3,
        op_jnz = `CTRL_OP_WIDTH'd4,
        op_jpo = `CTRL_OP_WIDTH'd5, // sign bit clear.
        op_jne = `CTRL_OP_WIDTH'd6  // sign bit set.
    } opcode_e;

    typedef enum logic [1:0] {
        st_clear = 2'd0,
        st_load  = 2'd1,
        st_run   = 2'd2
    } init_state_e;

endpackage

`default_nettype wire

//--- design/delay_line.sv
`timescale 1ns/1ps
`default_nettype none

module delay_line #(
    parameter int DEPTH = 1,
    parameter int WIDTH = 1
) (
    input  logic             clock,
    input  logic             rst_n,
    input  logic [WIDTH-1:0] in,
    output logic [WIDTH-1:0] out
);
    logic [WIDTH-1:0] stage [DEPTH];

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= in;
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign out = stage[DEPTH-1];
endmodule

`default_nettype wire

//--- design/pc_controller.sv
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_macros.svh"

module pc_controller (
    input  logic                         clock,
    input  logic                         rst_n,
    input  ctrl_pkg::opcode_e            op,
    input  logic [`CTRL_A_WIDTH-1:0]     a_value,
    input  logic [`CTRL_PC_WIDTH-1:0]    target,
    input  logic                         io_ready,
    output logic                         run,
    output logic [`CTRL_PC_WIDTH-1:0]    pc,
    output logic [`CTRL_THREAD_BITS-1:0] thread
);
    logic [`CTRL_THREAD_BITS-1:0] next_thread;
    logic                         jump;
    logic [`CTRL_PC_WIDTH-1:0]    target_d;
    logic                         io_ready_d;

    pc_mem_if mem_run ();
    pc_mem_if mem_load ();
    pc_mem_if mem_ram ();

    thread_counter u_thread_counter (
        .clock      (clock),
        .rst_n      (rst_n),
        .enable     (run),
        .thread     (thread),
        .next_thread(next_thread)
    );

    pc_init_fsm u_pc_init_fsm (.clock(clock), .rst_n(rst_n), .mem(mem_load), .run(run));

    branch_condition u_branch_condition (
        .clock  (clock),
        .rst_n  (rst_n),
        .op     (op),
        .a_value(a_value),
        .jump   (jump)
    );

    // line target and io_ready up with the jump decision.
    delay_line #(.DEPTH(1), .WIDTH(`CTRL_PC_WIDTH)) u_target_delay (
        .clock(clock), .rst_n(rst_n), .in(target), .out(target_d)
    );
    delay_line #(.DEPTH(1), .WIDTH(1)) u_io_ready_delay (
        .clock(clock), .rst_n(rst_n), .in(io_ready), .out(io_ready_d)
    );

    // ==================================================
    // loader owns the memory port until run rises
    // ==================================================
    assign mem_ram.write_en   = run ? mem_run.write_en   : mem_load.write_en;
    assign mem_ram.write_addr = run ? mem_run.write_addr : mem_load.write_addr;
    assign mem_ram.write_data = run ? mem_run.write_data : mem_load.write_data;
    assign mem_ram.read_addr  = mem_run.read_addr;
    assign mem_run.read_data  = mem_ram.read_data;

    thread_pc_memory u_thread_pc_memory (.clock(clock), .mem(mem_ram));

    pc_sequencer u_pc_sequencer (
        .clock      (clock),
        .rst_n      (rst_n),
        .run        (run),
        .thread     (thread),
        .next_thread(next_thread),
        .jump       (jump),
        .target     (target_d),
        .io_ready   (io_ready_d),
        .mem_wr     (mem_run),
        .mem_rd     (mem_run),
        .pc         (pc)
    );
endmodule

`default_nettype wire

//--- design/pc_init_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_macros.svh"

module pc_init_fsm (
    input  logic     clock,
    input  logic     rst_n,
    pc_mem_if.loader mem,
    output logic     run
);
    localparam logic [`CTRL_THREAD_BITS-1:0] LAST_THREAD =
        `CTRL_THREAD_BITS'(`CTRL_THREAD_COUNT - 1);

    ctrl_pkg::init_state_e        state;
    logic [`CTRL_THREAD_BITS-1:0] load_index;
    logic [`CTRL_PC_WIDTH-1:0]    start_pc;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state      <= ctrl_pkg::st_clear;
            load_index <= '0;
            run        <= 1'b0;
        end else begin
            run <= (state == ctrl_pkg::st_run); // first issue one cycle later.
            case (state)
                ctrl_pkg::st_clear: begin
                    load_index <= '0;
                    state      <= ctrl_pkg::st_load;
                end
                ctrl_pkg::st_load: begin
                    load_index <= load_index + `CTRL_THREAD_BITS'(1);
                    if (load_index == LAST_THREAD) begin
                        state <= ctrl_pkg::st_run;
                    end
                end
                default: state <= ctrl_pkg::st_run; // held until reset.
            endcase
        end
    end

    assign start_pc = `CTRL_PC_WIDTH'(load_index) * `CTRL_PC_WIDTH'(`CTRL_THREAD_STRIDE);

    assign mem.write_en   = (state == ctrl_pkg::st_load);
    assign mem.write_addr = load_index;
    assign mem.write_data = {start_pc, start_pc}; // no history yet.
endmodule

`default_nettype wire

//--- design/pc_mem_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_macros.svh"

interface pc_mem_if;
    logic                         write_en;
    logic [`CTRL_THREAD_BITS-1:0] write_addr;
    logic [2*`CTRL_PC_WIDTH-1:0]  write_data; // {pc, previous pc}.
    logic [`CTRL_THREAD_BITS-1:0] read_addr;
    logic [2*`CTRL_PC_WIDTH-1:0]  read_data;

    modport writer (output write_en, write_addr, write_data);
    modport reader (output read_addr, input read_data);
    modport loader (output write_en, write_addr, write_data);
    modport memory (
        input  write_en, write_addr, write_data, read_addr,
        output read_data
    );
endinterface

`default_nettype wire

//--- design/pc_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_macros.svh"

module pc_sequencer (
    input  logic                         clock,
    input  logic                         rst_n,
    input  logic                         run,
    input  logic [`CTRL_THREAD_BITS-1:0] thread,
    input  logic [`CTRL_THREAD_BITS-1:0] next_thread,
    input  logic                         jump,
    input  logic [`CTRL_PC_WIDTH-1:0]    target,
    input  logic                         io_ready,
    pc_mem_if.writer                     mem_wr,
    pc_mem_if.reader                     mem_rd,
    output logic [`CTRL_PC_WIDTH-1:0]    pc
);
    logic [`CTRL_PC_WIDTH-1:0]    issue_pc;
    logic [`CTRL_PC_WIDTH-1:0]    issue_prev;
    logic                         s1_valid;
    logic                         s2_valid;
    logic [`CTRL_PC_WIDTH-1:0]    s1_pc;
    logic [`CTRL_PC_WIDTH-1:0]    s1_prev;
    logic [`CTRL_PC_WIDTH-1:0]    s2_pc;
    logic [`CTRL_PC_WIDTH-1:0]    s2_prev;
    logic [`CTRL_THREAD_BITS-1:0] s1_thread;
    logic [`CTRL_THREAD_BITS-1:0] s2_thread;
    logic [`CTRL_PC_WIDTH-1:0]    next_pc;

    assign mem_rd.read_addr       = next_thread; // lands in the issue cycle.
    assign {issue_pc, issue_prev} = mem_rd.read_data;
    assign pc                     = run ? issue_pc : '0;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= run;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clock) begin
        s1_pc     <= issue_pc;
        s1_prev   <= issue_prev;
        s1_thread <= thread;
        s2_pc     <= s1_pc;
        s2_prev   <= s1_prev;
        s2_thread <= s1_thread;
    end

    assign next_pc = jump ? target : s2_pc + `CTRL_PC_WIDTH'(1);

    // a stalled thread keeps its whole pair.
    assign mem_wr.write_en   = s2_valid;
    assign mem_wr.write_addr = s2_thread;
    assign mem_wr.write_data = io_ready ? {next_pc, s2_pc} : {s2_pc, s2_prev};
endmodule

`default_nettype wire

//--- design/thread_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_macros.svh"

module thread_counter (
    input  logic                         clock,
    input  logic                         rst_n,
    input  logic                         enable,
    output logic [`CTRL_THREAD_BITS-1:0] thread,
    output logic [`CTRL_THREAD_BITS-1:0] next_thread
);
    localparam logic [`CTRL_THREAD_BITS-1:0] LAST_THREAD =
        `CTRL_THREAD_BITS'(`CTRL_THREAD_COUNT - 1);

    logic [`CTRL_THREAD_BITS-1:0] thread_step;

    // wrap after the last thread.
    always_comb begin
        if (thread == LAST_THREAD) begin
            thread_step = '0;
        end else begin
            thread_step = thread + `CTRL_THREAD_BITS'(1);
        end
    end

    assign next_thread = enable ? thread_step : thread; // read-ahead address.

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            thread <= '0;
        end else begin
            thread <= next_thread;
        end
    end
endmodule

`default_nettype wire

//--- design/thread_pc_memory.sv
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_macros.svh"

module thread_pc_memory (
    input logic      clock,
    pc_mem_if.memory mem
);
    // one {pc, previous pc} pair per thread.
    logic [2*`CTRL_PC_WIDTH-1:0] pc_ram [`CTRL_THREAD_COUNT];

    always_ff @(posedge clock) begin
        if (mem.write_en) begin
            pc_ram[mem.write_addr] <= mem.write_data;
        end
    end

    // registered read port.
    always_ff @(posedge clock) begin
        mem.read_data <= pc_ram[mem.read_addr];
    end
endmodule

`default_nettype wire

//--- tests/tb_pc_controller.sv
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_macros.svh"

module tb_pc_controller;

    localparam int THREADS     = `CTRL_THREAD_COUNT;
    localparam int HALF_PERIOD = 20;
    localparam int RUN_TIMEOUT = 64;
    localparam int RND_ROUNDS  = 40;
    localparam int TEST_COUNT  = 5;
    localparam int ROW_COUNT   = 8 + 48 + 16 + 24 + (RND_ROUNDS + 1) * THREADS;

    typedef struct packed {
        ctrl_pkg::opcode_e         op;
        logic [`CTRL_A_WIDTH-1:0]  a_value;
        logic [`CTRL_PC_WIDTH-1:0] target;
        logic                      io_ready;
    } row_t;

    logic                         clock;
    logic                         rst_n;
    ctrl_pkg::opcode_e            op;
    logic [`CTRL_A_WIDTH-1:0]     a_value;
    logic [`CTRL_PC_WIDTH-1:0]    target;
    logic                         io_ready;
    logic                         run;
    logic [`CTRL_PC_WIDTH-1:0]    pc;
    logic [`CTRL_THREAD_BITS-1:0] thread;

    row_t  table_rows [ROW_COUNT];
    int    test_first [TEST_COUNT];
    int    test_rows [TEST_COUNT];
    string test_names [TEST_COUNT];
    int    row_fill;

    logic [`CTRL_PC_WIDTH-1:0]    model_pc [THREADS]; // reference pc per thread.
    logic [`CTRL_THREAD_BITS-1:0] expect_thread;
    int                           checks;
    int                           errors;
    int                           tests_passed;

    pc_controller dut (
        .clock   (clock),
        .rst_n   (rst_n),
        .op      (op),
        .a_value (a_value),
        .target  (target),
        .io_ready(io_ready),
        .run     (run),
        .pc      (pc),
        .thread  (thread)
    );

    initial begin
        clock = 1'b0;
        forever #HALF_PERIOD clock = ~clock;
    end

    // ==================================================
    // reference model
    // ==================================================
    function automatic logic [`CTRL_PC_WIDTH-1:0] expected_next(
        input logic [`CTRL_PC_WIDTH-1:0] cur,
        input row_t                      r
    );
        logic taken;
        case (r.op)
            ctrl_pkg::op_jmp: taken = 1'b1;
            ctrl_pkg::op_jze: taken = (r.a_value == 16'h0000);
            ctrl_pkg::op_jnz: taken = (r.a_value != 16'h0000);
            ctrl_pkg::op_jpo: taken = ~r.a_value[`CTRL_A_WIDTH-1];
            ctrl_pkg::op_jne: taken = r.a_value[`CTRL_A_WIDTH-1];
            default:          taken = 1'b0;
        endcase
        if (!r.io_ready) begin
            return cur; // retry.
        end else if (taken) begin
            return r.target;
        end
        return cur + `CTRL_PC_WIDTH'(1);
    endfunction

    // ==================================================
    // stimulus table
    // ==================================================
    task automatic add_row(
        input ctrl_pkg::opcode_e         o,
        input logic [`CTRL_A_WIDTH-1:0]  a,
        input logic [`CTRL_PC_WIDTH-1:0] t,
        input logic                      rdy
    );
        table_rows[row_fill] = '{op: o, a_value: a, target: t, io_ready: rdy};
        row_fill++;
    endtask

    task automatic open_test(input int index, input string name);
        test_names[index] = name;
        test_first[index] = row_fill;
    endtask

    task automatic build_table();
        ctrl_pkg::opcode_e        cond_ops [5];
        logic [`CTRL_A_WIDTH-1:0] cond_a [3];
        ctrl_pkg::opcode_e        o;
        cond_ops = '{ctrl_pkg::op_jze, ctrl_pkg::op_jnz, ctrl_pkg::op_jpo,
                     ctrl_pkg::op_jne, ctrl_pkg::op_jmp};
        cond_a   = '{16'h0000, 16'h1234, 16'h8001}; // zero, positive, negative.
        row_fill = 0;

        open_test(0, "start-up");
        for (int i = 0; i < THREADS; i++) begin
            add_row(ctrl_pkg::op_nop, 16'h0000, 10'h000, 1'b1);
        end

        open_test(1, "sequential flow");
        for (int i = 0; i < 6 * THREADS; i++) begin
            o = (i % 2 == 0) ? ctrl_pkg::op_nop : ctrl_pkg::op_add;
            if (i / THREADS == 2) begin
                add_row(ctrl_pkg::op_jmp, 16'h0000, 10'h3fe, 1'b1); // park near the wrap.
            end else begin
                add_row(o, `CTRL_A_WIDTH'($urandom), `CTRL_PC_WIDTH'($urandom), 1'b1);
            end
        end

        open_test(2, "conditional jumps");
        for (int k = 0; k < 15; k++) begin
            add_row(cond_ops[k / 3], cond_a[k % 3], `CTRL_PC_WIDTH'(32'h200 + k * 5), 1'b1);
        end
        add_row(ctrl_pkg::op_nop, 16'h0000, 10'h000, 1'b1);

        open_test(3, "stall");
        for (int i = 0; i < 3 * THREADS; i++) begin
            if (i % THREADS == 2 || i % THREADS == 5) begin
                add_row(ctrl_pkg::op_jmp, 16'h0000, 10'h3f0, 1'b0);
            end else begin
                add_row(ctrl_pkg::op_add, 16'h0001, `CTRL_PC_WIDTH'($urandom), 1'b1);
            end
        end

        open_test(4, "mixed random");
        for (int i = 0; i < RND_ROUNDS * THREADS; i++) begin
            // 7 and 8 are not opcodes.
            o = ctrl_pkg::opcode_e'(`CTRL_OP_WIDTH'((i * 5 + i / THREADS) % 9));
            add_row(o, (i % 6 == 0) ? 16'h0000 : `CTRL_A_WIDTH'($urandom),
                    `CTRL_PC_WIDTH'($urandom), (i % 7) != 3);
        end
        for (int i = 0; i < THREADS; i++) begin
            add_row(ctrl_pkg::op_nop, 16'h0000, 10'h000, 1'b1); // last round gets checked.
        end

        for (int t = 0; t < TEST_COUNT - 1; t++) begin
            test_rows[t] = test_first[t + 1] - test_first[t];
        end
        test_rows[TEST_COUNT-1] = row_fill - test_first[TEST_COUNT-1];
    endtask

    // ==================================================
    // per-cycle checks and drive
    // ==================================================
    task automatic issue_row(input row_t r);
        checks += 3;
        if (run !== 1'b1) begin
            $display("Mismatch run: expected 0x1, got 0x%h", run);
            errors++;
        end
        if (thread !== expect_thread) begin
            $display("Mismatch thread: expected 0x%h, got 0x%h", expect_thread, thread);
            errors++;
        end
        if (pc !== model_pc[expect_thread]) begin
            $display("Mismatch pc (thread %0d): expected 0x%h, got 0x%h",
                     expect_thread, model_pc[expect_thread], pc);
            errors++;
        end
        @(posedge clock);
        op       <= r.op;
        a_value  <= r.a_value;
        target   <= r.target;
        io_ready <= r.io_ready;
        model_pc[expect_thread] = expected_next(model_pc[expect_thread], r);
        if (expect_thread == `CTRL_THREAD_BITS'(THREADS - 1)) begin
            expect_thread = '0;
        end else begin
            expect_thread = expect_thread + `CTRL_THREAD_BITS'(1);
        end
        @(negedge clock);
    endtask

    task automatic wait_for_run(output logic started, output int low_cycles);
        started    = 1'b0;
        low_cycles = 0;
        while (!started && low_cycles < RUN_TIMEOUT) begin
            @(negedge clock);
            if (run === 1'b1) begin
                started = 1'b1;
            end else begin
                low_cycles++;
                checks += 2;
                if (pc !== '0) begin
                    $display("Mismatch pc: expected 0x000, got 0x%h", pc);
                    errors++;
                end
                if (thread !== '0) begin
                    $display("Mismatch thread: expected 0x0, got 0x%h", thread);
                    errors++;
                end
            end
        end
    endtask

    task automatic report_test(input int index, input int failures);
        if (failures == 0) begin
            tests_passed++;
            $display("test %0d %s: passed", index + 1, test_names[index]);
        end else begin
            $display("test %0d %s: failed with %0d errors", index + 1, test_names[index],
                     failures);
        end
    endtask

    // ==================================================
    // main sequence
    // ==================================================
    initial begin
        logic started;
        int   low_cycles;
        int   mark;
        void'($urandom(98191));
        rst_n         = 1'b0;
        op            = ctrl_pkg::op_nop;
        a_value       = '0;
        target        = '0;
        io_ready      = 1'b1;
        checks        = 0;
        errors        = 0;
        tests_passed  = 0;
        expect_thread = '0;
        build_table();
        for (int i = 0; i < THREADS; i++) begin
            model_pc[i] = `CTRL_PC_WIDTH'(i * `CTRL_THREAD_STRIDE);
        end

        repeat (8) @(posedge clock);
        rst_n <= 1'b1;
        mark = errors;
        wait_for_run(started, low_cycles);
        if (!started) begin
            $display("test 1 start-up: run did not rise within %0d cycles after reset",
                     RUN_TIMEOUT);
            errors++;
        end else begin
            checks++;
            if (low_cycles != THREADS + 2) begin
                $display("Mismatch start-up latency: expected 0x%h, got 0x%h",
                         THREADS + 2, low_cycles);
                errors++;
            end
            for (int t = 0; t < TEST_COUNT; t++) begin
                for (int r = 0; r < test_rows[t]; r++) begin
                    issue_row(table_rows[test_first[t] + r]);
                end
                report_test(t, errors - mark);
                mark = errors;
            end
        end

        $display("tests passed %0d of %0d, checks %0d, errors %0d",
                 tests_passed, TEST_COUNT, checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
